/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_subsystem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator's exit status is not trusted, the log decides
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/axi_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model #(
  parameter int depth = 1024
) (
  input  logic           clock,
  input  logic           reset,
  input  mem_pkg::addr_t s_axi_awaddr,
  input  logic           s_axi_awvalid,
  output logic           s_axi_awready,
  input  mem_pkg::data_t s_axi_wdata,
  input  mem_pkg::strb_t s_axi_wstrb,
  input  logic           s_axi_wvalid,
  output logic           s_axi_wready,
  output axi_pkg::resp_t s_axi_bresp,
  output logic           s_axi_bvalid,
  input  logic           s_axi_bready,
  input  mem_pkg::addr_t s_axi_araddr,
  input  logic           s_axi_arvalid,
  output logic           s_axi_arready,
  output mem_pkg::data_t s_axi_rdata,
  output axi_pkg::resp_t s_axi_rresp,
  output logic           s_axi_rlast,
  output logic           s_axi_rvalid,
  input  logic           s_axi_rready
);
  import mem_pkg::*;
  import axi_pkg::*;

  localparam int index_bits = $clog2(depth);

  data_t mem [depth];
  logic  aw_done;
  logic  w_done;
  logic  ar_done;
  addr_t waddr;
  data_t wdata;
  strb_t wstrb;
  addr_t raddr;

  // every word starts from a value built out of its whole index
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
    end
  end

  assign s_axi_bresp = resp_okay;
  assign s_axi_rresp = resp_okay;
  assign s_axi_rlast = s_axi_rvalid;

  always @(posedge clock) begin
    if (reset == 1'b0) begin
      s_axi_awready <= 1'b0;
      s_axi_wready <= 1'b0;
      s_axi_bvalid <= 1'b0;
      s_axi_arready <= 1'b0;
      s_axi_rvalid <= 1'b0;
      aw_done <= 1'b0;
      w_done <= 1'b0;
      ar_done <= 1'b0;
    end else begin
      // each ready comes up at random cycles and accepts one beat per transaction
      if (s_axi_awvalid && s_axi_awready) begin
        aw_done <= 1'b1;
        waddr <= s_axi_awaddr;
        s_axi_awready <= 1'b0;
      end else begin
        s_axi_awready <= !aw_done && ($urandom_range(3, 0) != 0);
      end
      if (s_axi_wvalid && s_axi_wready) begin
        w_done <= 1'b1;
        wdata <= s_axi_wdata;
        wstrb <= s_axi_wstrb;
        s_axi_wready <= 1'b0;
      end else begin
        s_axi_wready <= !w_done && ($urandom_range(3, 0) != 0);
      end
      if (s_axi_bvalid) begin
        if (s_axi_bready) begin
          s_axi_bvalid <= 1'b0;
          aw_done <= 1'b0;
          w_done <= 1'b0;
        end
      end else if (aw_done && w_done && $urandom_range(3, 0) == 0) begin
        for (int b = 0; b < 8; b++) begin
          if (wstrb[b]) begin
            mem[waddr[index_bits+2:3]][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
        s_axi_bvalid <= 1'b1;
      end
      if (s_axi_arvalid && s_axi_arready) begin
        ar_done <= 1'b1;
        raddr <= s_axi_araddr;
        s_axi_arready <= 1'b0;
      end else begin
        s_axi_arready <= !ar_done && ($urandom_range(3, 0) != 0);
      end
      if (s_axi_rvalid) begin
        if (s_axi_rready) begin
          s_axi_rvalid <= 1'b0;
          ar_done <= 1'b0;
        end
      end else if (ar_done && $urandom_range(3, 0) == 0) begin
        s_axi_rdata <= mem[raddr[index_bits+2:3]];
        s_axi_rvalid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_mem_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsystem;
  import mem_pkg::*;
  import axi_pkg::*;

  localparam int requests = 200;
  localparam int timeout_cycles = 2 * requests * 40;

  logic   clock;
  logic   reset;
  logic   fetch_valid;
  logic   fetch_instr;
  addr_t  fetch_addr;
  data_t  fetch_rdata;
  logic   fetch_ready;
  logic   data_valid;
  logic   data_instr;
  addr_t  data_addr;
  data_t  data_wdata;
  strb_t  data_wstrb;
  data_t  data_rdata;
  logic   data_ready;
  addr_t  m_axi_awaddr, m_axi_araddr;
  len_t   m_axi_awlen, m_axi_arlen;
  size_t  m_axi_awsize, m_axi_arsize;
  burst_t m_axi_awburst, m_axi_arburst;
  cache_t m_axi_awcache, m_axi_arcache;
  prot_t  m_axi_awprot, m_axi_arprot;
  qos_t   m_axi_awqos, m_axi_arqos;
  logic   m_axi_awlock, m_axi_awvalid, m_axi_awready;
  logic   m_axi_arlock, m_axi_arvalid, m_axi_arready;
  data_t  m_axi_wdata, m_axi_rdata;
  strb_t  m_axi_wstrb;
  logic   m_axi_wlast, m_axi_wvalid, m_axi_wready;
  resp_t  m_axi_bresp, m_axi_rresp;
  logic   m_axi_bvalid, m_axi_bready;
  logic   m_axi_rlast, m_axi_rvalid, m_axi_rready;

  data_t       ref_mem [1024];
  data_t       fetch_expect;
  data_t       data_expect;
  int          cycle = 0;
  int          addr_xfers = 0;
  logic        aw_xfer, ar_xfer, addr_xfer, xfer_instr;
  logic        last_read = 1'b0;
  logic        last_instr = 1'b0;
  addr_t       last_addr = '0;
  logic [33:0] last_xfer, fetch_xfer_expect, data_xfer_expect;
  logic [23:0] aw_fields, ar_fields;
  logic [35:0] aw_payload, aw_hold, ar_payload, ar_hold;
  logic [72:0] w_payload, w_hold;
  logic [6:0]  idle_outputs;
  logic        done_last = 1'b0;
  logic        fair_check = 1'b0;
  logic        fair_instr = 1'b0;
  owner_t      served = owner_fetch;

  mem_subsystem dut (.*);

  axi_mem_model #(.depth(1024)) memory (
    .clock, .reset,
    .s_axi_awaddr(m_axi_awaddr), .s_axi_awvalid(m_axi_awvalid),
    .s_axi_awready(m_axi_awready),
    .s_axi_wdata(m_axi_wdata), .s_axi_wstrb(m_axi_wstrb),
    .s_axi_wvalid(m_axi_wvalid), .s_axi_wready(m_axi_wready),
    .s_axi_bresp(m_axi_bresp), .s_axi_bvalid(m_axi_bvalid), .s_axi_bready(m_axi_bready),
    .s_axi_araddr(m_axi_araddr), .s_axi_arvalid(m_axi_arvalid),
    .s_axi_arready(m_axi_arready),
    .s_axi_rdata(m_axi_rdata), .s_axi_rresp(m_axi_rresp), .s_axi_rlast(m_axi_rlast),
    .s_axi_rvalid(m_axi_rvalid), .s_axi_rready(m_axi_rready)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #20 clock = ~clock;
    end
  end

  assign fetch_expect = ref_mem[fetch_addr[12:3]];
  assign data_expect = ref_mem[data_addr[12:3]];
  assign aw_xfer = m_axi_awvalid && m_axi_awready;
  assign ar_xfer = m_axi_arvalid && m_axi_arready;
  assign addr_xfer = aw_xfer || ar_xfer;
  assign xfer_instr = ar_xfer ? m_axi_arprot[prot_instr_bit] : m_axi_awprot[prot_instr_bit];
  assign last_xfer = {last_read, last_instr, last_addr};
  assign fetch_xfer_expect = {1'b1, fetch_instr, fetch_addr[31:2], 2'b00};
  assign data_xfer_expect = {~|data_wstrb, data_instr, data_addr[31:2], 2'b00};
  assign aw_fields = {m_axi_awaddr[1:0], m_axi_awlen, m_axi_awsize, m_axi_awburst,
                      m_axi_awlock, m_axi_awcache, m_axi_awqos};
  assign ar_fields = {m_axi_araddr[1:0], m_axi_arlen, m_axi_arsize, m_axi_arburst,
                      m_axi_arlock, m_axi_arcache, m_axi_arqos};
  assign aw_payload = {m_axi_awvalid, m_axi_awprot, m_axi_awaddr};
  assign ar_payload = {m_axi_arvalid, m_axi_arprot, m_axi_araddr};
  assign w_payload = {m_axi_wvalid, m_axi_wstrb, m_axi_wdata};
  assign idle_outputs = {m_axi_awvalid, m_axi_wvalid, m_axi_arvalid, m_axi_bready,
                         m_axi_rready, fetch_ready, data_ready};

  // follows the bus so that each port ready can be matched to its address transfer
  always @(posedge clock) begin
    cycle <= cycle + 1;
    aw_hold <= aw_payload;
    ar_hold <= ar_payload;
    w_hold <= w_payload;
    if (addr_xfer) begin
      last_read <= ar_xfer;
      last_instr <= xfer_instr;
      last_addr <= ar_xfer ? m_axi_araddr : m_axi_awaddr;
      addr_xfers <= addr_xfers + 1;
      fair_check <= 1'b0;
    end
    if (fetch_ready || data_ready) begin
      addr_xfers <= 0;
      served <= fetch_ready ? owner_fetch : owner_data;
    end
    done_last <= fetch_ready || data_ready;
    // both waiting right after a completion, so the other one must win
    if (done_last && fetch_valid && data_valid) begin
      fair_check <= 1'b1;
      fair_instr <= (served == owner_data);
    end
    if (data_ready && data_wstrb != '0) begin
      for (int b = 0; b < 8; b++) begin
        if (data_wstrb[b]) begin
          ref_mem[data_addr[12:3]][8*b +: 8] <= data_wdata[8*b +: 8];
        end
      end
    end
  end

  task automatic report_error(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
    $display("** Error at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    $display("sim failed");
    $fatal(1);
  endtask

  fetch_data: assert property (@(posedge clock) disable iff (reset == 1'b0)
    fetch_ready |-> fetch_rdata == fetch_expect)
    else report_error("fetch_rdata", 128'($sampled(fetch_expect)), 128'($sampled(fetch_rdata)));

  data_read: assert property (@(posedge clock) disable iff (reset == 1'b0)
    data_ready && ~|data_wstrb |-> data_rdata == data_expect)
    else report_error("data_rdata", 128'($sampled(data_expect)), 128'($sampled(data_rdata)));

  fetch_xfer: assert property (@(posedge clock) disable iff (reset == 1'b0)
    fetch_ready |-> last_xfer == fetch_xfer_expect)
    else report_error("fetch {read, prot[2], addr}", 128'($sampled(fetch_xfer_expect)),
                      128'($sampled(last_xfer)));

  data_xfer: assert property (@(posedge clock) disable iff (reset == 1'b0)
    data_ready |-> last_xfer == data_xfer_expect)
    else report_error("data {read, prot[2], addr}", 128'($sampled(data_xfer_expect)),
                      128'($sampled(last_xfer)));

  one_ready: assert property (@(posedge clock) disable iff (reset == 1'b0)
    fetch_ready || data_ready |-> addr_xfers == 1)
    else report_error("address transfers per ready", 128'(1), 128'($sampled(addr_xfers)));

  aw_rules: assert property (@(posedge clock) disable iff (reset == 1'b0)
    aw_xfer |-> aw_fields == '0)
    else report_error("aw {addr[1:0], len, size, burst, lock, cache, qos}", 128'(0),
                      128'($sampled(aw_fields)));

  ar_rules: assert property (@(posedge clock) disable iff (reset == 1'b0)
    ar_xfer |-> ar_fields == '0)
    else report_error("ar {addr[1:0], len, size, burst, lock, cache, qos}", 128'(0),
                      128'($sampled(ar_fields)));

  w_last: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_wvalid && m_axi_wready |-> m_axi_wlast)
    else report_error("m_axi_wlast", 128'(1), 128'($sampled(m_axi_wlast)));

  // the slave only answers a running transaction, whose response ready is already up
  r_ready_up: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_rvalid |-> m_axi_rready)
    else report_error("m_axi_rready", 128'(1), 128'($sampled(m_axi_rready)));

  b_ready_up: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_bvalid |-> m_axi_bready)
    else report_error("m_axi_bready", 128'(1), 128'($sampled(m_axi_bready)));

  aw_stall: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_awvalid && !m_axi_awready |=> aw_payload == aw_hold)
    else report_error("aw {valid, prot, addr}", 128'($sampled(aw_hold)),
                      128'($sampled(aw_payload)));

  w_stall: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_wvalid && !m_axi_wready |=> w_payload == w_hold)
    else report_error("w {valid, strb, data}", 128'($sampled(w_hold)),
                      128'($sampled(w_payload)));

  ar_stall: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_arvalid && !m_axi_arready |=> ar_payload == ar_hold)
    else report_error("ar {valid, prot, addr}", 128'($sampled(ar_hold)),
                      128'($sampled(ar_payload)));

  round_robin: assert property (@(posedge clock) disable iff (reset == 1'b0)
    fair_check && addr_xfer |-> xfer_instr == fair_instr)
    else report_error("prot[2] of next grant", 128'($sampled(fair_instr)),
                      128'($sampled(xfer_instr)));

  reset_outputs: assert property (@(posedge clock)
    cycle >= 1 && cycle <= 6 |-> idle_outputs == '0)
    else report_error("{aw, w, ar valid, bready, rready, port readys}", 128'(0),
                      128'($sampled(idle_outputs)));

  task automatic run_fetch();
    for (int n = 0; n < requests; n++) begin
      fetch_valid <= 1'b1;
      fetch_addr <= addr_t'($urandom_range(511, 0));
      @(posedge clock);
      while (!fetch_ready) begin
        @(posedge clock);
      end
      if ($urandom_range(3, 0) == 0) begin
        fetch_valid <= 1'b0;
        repeat ($urandom_range(3, 1)) @(posedge clock);
      end
    end
    fetch_valid <= 1'b0;
  endtask

  // half the data requests are reads, the rest write a random set of bytes
  task automatic run_data();
    for (int n = 0; n < requests; n++) begin
      data_valid <= 1'b1;
      data_addr <= addr_t'($urandom_range(511, 0));
      data_wdata <= {$urandom, $urandom};
      data_wstrb <= ($urandom_range(1, 0) == 0) ? '0 : strb_t'($urandom);
      @(posedge clock);
      while (!data_ready) begin
        @(posedge clock);
      end
      if ($urandom_range(3, 0) == 0) begin
        data_valid <= 1'b0;
        repeat ($urandom_range(3, 1)) @(posedge clock);
      end
    end
    data_valid <= 1'b0;
  endtask

  initial begin
    while (cycle < timeout_cycles) begin
      @(posedge clock);
    end
    $display("timeout: the requesters did not finish within %0d cycles", timeout_cycles);
    $display("sim failed");
    $fatal(1);
  end

  initial begin
    void'($urandom(64205));
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
    end
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = 1'b1;
    fetch_addr = '0;
    data_valid = 1'b0;
    data_instr = 1'b0;
    data_addr = '0;
    data_wdata = '0;
    data_wstrb = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    fork
      run_fetch();
      run_data();
    join
    @(posedge clock);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/axi_master.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_master (
  input  logic             clock,
  input  logic             reset,
  input  logic             req_valid,
  input  logic             req_instr,
  input  mem_pkg::addr_t   req_addr,
  input  mem_pkg::data_t   req_wdata,
  input  mem_pkg::strb_t   req_wstrb,
  output mem_pkg::data_t   req_rdata,
  output logic             req_ready,
  // write address channel
  output mem_pkg::addr_t   m_axi_awaddr,
  output axi_pkg::len_t    m_axi_awlen,
  output axi_pkg::size_t   m_axi_awsize,
  output axi_pkg::burst_t  m_axi_awburst,
  output logic             m_axi_awlock,
  output axi_pkg::cache_t  m_axi_awcache,
  output axi_pkg::prot_t   m_axi_awprot,
  output axi_pkg::qos_t    m_axi_awqos,
  output logic             m_axi_awvalid,
  input  logic             m_axi_awready,
  // write data channel
  output mem_pkg::data_t   m_axi_wdata,
  output mem_pkg::strb_t   m_axi_wstrb,
  output logic             m_axi_wlast,
  output logic             m_axi_wvalid,
  input  logic             m_axi_wready,
  // write response channel
  input  axi_pkg::resp_t   m_axi_bresp,
  input  logic             m_axi_bvalid,
  output logic             m_axi_bready,
  // read address channel
  output mem_pkg::addr_t   m_axi_araddr,
  output axi_pkg::len_t    m_axi_arlen,
  output axi_pkg::size_t   m_axi_arsize,
  output axi_pkg::burst_t  m_axi_arburst,
  output logic             m_axi_arlock,
  output axi_pkg::cache_t  m_axi_arcache,
  output axi_pkg::prot_t   m_axi_arprot,
  output axi_pkg::qos_t    m_axi_arqos,
  output logic             m_axi_arvalid,
  input  logic             m_axi_arready,
  // read data channel
  input  mem_pkg::data_t   m_axi_rdata,
  input  axi_pkg::resp_t   m_axi_rresp,
  input  logic             m_axi_rlast,
  input  logic             m_axi_rvalid,
  output logic             m_axi_rready
);
  import mem_pkg::*;
  import axi_pkg::*;

  axi_state_t state;
  axi_state_t state_reg;

  logic  awvalid;
  logic  awvalid_reg;
  logic  wvalid;
  logic  wvalid_reg;
  logic  bready;
  logic  bready_reg;
  logic  arvalid;
  logic  arvalid_reg;
  logic  rready;
  logic  rready_reg;
  logic  ready;
  logic  ready_reg;
  addr_t addr;
  addr_t addr_reg;
  prot_t prot;
  prot_t prot_reg;
  data_t wdata;
  data_t wdata_reg;
  strb_t wstrb;
  strb_t wstrb_reg;
  data_t rdata;
  data_t rdata_reg;

  always_comb begin
    state = state_reg;
    // each request channel drops its valid only on its own ready
    awvalid = awvalid_reg && !m_axi_awready;
    wvalid = wvalid_reg && !m_axi_wready;
    arvalid = arvalid_reg && !m_axi_arready;
    bready = bready_reg;
    rready = rready_reg;
    ready = 1'b0;
    addr = addr_reg;
    prot = prot_reg;
    wdata = wdata_reg;
    wstrb = wstrb_reg;
    rdata = rdata_reg;
    case (state_reg)
      axi_idle: begin
        if (req_valid) begin
          addr = {req_addr[31:2], 2'b00};
          prot = prot_none;
          prot[prot_instr_bit] = req_instr;
          wdata = req_wdata;
          wstrb = req_wstrb;
          if (req_wstrb == '0) begin
            state = axi_load;
            arvalid = 1'b1;
            rready = 1'b1;
          end else begin
            state = axi_store;
            awvalid = 1'b1;
            wvalid = 1'b1;
            bready = 1'b1;
          end
        end
      end
      axi_load: begin
        if (m_axi_rvalid) begin
          state = axi_idle;
          rready = 1'b0;
          rdata = m_axi_rdata;
          ready = 1'b1;
        end
      end
      axi_store: begin
        if (m_axi_bvalid) begin
          state = axi_idle;
          bready = 1'b0;
          ready = 1'b1;
        end
      end
      default: begin
        state = axi_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state_reg <= axi_idle;
      awvalid_reg <= 1'b0;
      wvalid_reg <= 1'b0;
      bready_reg <= 1'b0;
      arvalid_reg <= 1'b0;
      rready_reg <= 1'b0;
      ready_reg <= 1'b0;
    end else begin
      state_reg <= state;
      awvalid_reg <= awvalid;
      wvalid_reg <= wvalid;
      bready_reg <= bready;
      arvalid_reg <= arvalid;
      rready_reg <= rready;
      ready_reg <= ready;
    end
  end

  always_ff @(posedge clock) begin
    addr_reg <= addr;
    prot_reg <= prot;
    wdata_reg <= wdata;
    wstrb_reg <= wstrb;
    rdata_reg <= rdata;
  end

  assign m_axi_awaddr = addr_reg;
  assign m_axi_awlen = len_single;
  assign m_axi_awsize = size_default;
  assign m_axi_awburst = burst_fixed;
  assign m_axi_awlock = lock_normal;
  assign m_axi_awcache = cache_none;
  assign m_axi_awprot = prot_reg;
  assign m_axi_awqos = qos_none;
  assign m_axi_awvalid = awvalid_reg;

  // the only write beat is also the last one
  assign m_axi_wdata = wdata_reg;
  assign m_axi_wstrb = wstrb_reg;
  assign m_axi_wlast = wvalid_reg;
  assign m_axi_wvalid = wvalid_reg;
  assign m_axi_bready = bready_reg;

  assign m_axi_araddr = addr_reg;
  assign m_axi_arlen = len_single;
  assign m_axi_arsize = size_default;
  assign m_axi_arburst = burst_fixed;
  assign m_axi_arlock = lock_normal;
  assign m_axi_arcache = cache_none;
  assign m_axi_arprot = prot_reg;
  assign m_axi_arqos = qos_none;
  assign m_axi_arvalid = arvalid_reg;
  assign m_axi_rready = rready_reg;

  assign req_rdata = rdata_reg;
  assign req_ready = ready_reg;

  aw_held: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_awvalid && !m_axi_awready |=>
      m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awprot));

  w_held: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_wvalid && !m_axi_wready |=>
      m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb));

  ar_held: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arprot));

  // a single-beat read must come back with its last flag
  r_single_beat: assert property (@(posedge clock) disable iff (reset == 1'b0)
    m_axi_rvalid && m_axi_rready |-> m_axi_rlast);

  ready_pulse: assert property (@(posedge clock) disable iff (reset == 1'b0)
    req_ready |=> !req_ready);

endmodule

`default_nettype wire

/* hw/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;
  typedef logic [3:0] qos_t;
  typedef logic [2:0] prot_t;
  typedef logic [1:0] resp_t;

  typedef enum logic [1:0] {
    axi_idle,
    axi_load,
    axi_store
  } axi_state_t;

  // every transaction is a single beat with default attributes
  localparam len_t len_single = 8'd0;
  localparam size_t size_default = 3'd0;
  localparam burst_t burst_fixed = 2'b00;
  localparam logic lock_normal = 1'b0;
  localparam cache_t cache_none = 4'd0;
  localparam qos_t qos_none = 4'd0;

  // unprivileged secure data access, bit 2 marks an instruction fetch
  localparam prot_t prot_none = 3'b000;
  localparam int prot_instr_bit = 2;

  localparam resp_t resp_okay = 2'b00;

endpackage

`default_nettype wire

/* hw/mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  logic           clock,
  input  logic           reset,
  input  logic           fetch_valid,
  input  logic           fetch_instr,
  input  mem_pkg::addr_t fetch_addr,
  output mem_pkg::data_t fetch_rdata,
  output logic           fetch_ready,
  input  logic           data_valid,
  input  logic           data_instr,
  input  mem_pkg::addr_t data_addr,
  input  mem_pkg::data_t data_wdata,
  input  mem_pkg::strb_t data_wstrb,
  output mem_pkg::data_t data_rdata,
  output logic           data_ready,
  output logic           req_valid,
  output logic           req_instr,
  output mem_pkg::addr_t req_addr,
  output mem_pkg::data_t req_wdata,
  output mem_pkg::strb_t req_wstrb,
  input  logic           req_ready,
  input  mem_pkg::data_t req_rdata
);
  import mem_pkg::*;

  arb_state_t state_reg;
  owner_t     owner_reg;
  owner_t     last_reg;
  owner_t     grant;
  logic       pending;

  assign pending = fetch_valid || data_valid;

  // on a tie the requester that was not served last wins
  always_comb begin
    if (fetch_valid && data_valid) begin
      grant = (last_reg == owner_fetch) ? owner_data : owner_fetch;
    end else if (data_valid) begin
      grant = owner_data;
    end else begin
      grant = owner_fetch;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state_reg <= arb_idle;
      owner_reg <= owner_fetch;
      last_reg <= owner_data;
      req_valid <= 1'b0;
    end else begin
      req_valid <= 1'b0;
      case (state_reg)
        arb_idle: begin
          if (pending) begin
            state_reg <= arb_busy;
            owner_reg <= grant;
            req_valid <= 1'b1;
          end
        end
        arb_busy: begin
          if (req_ready) begin
            state_reg <= arb_idle;
            last_reg <= owner_reg;
          end
        end
        default: begin
          state_reg <= arb_idle;
        end
      endcase
    end
  end

  // a fetch never writes, so its strobes are forced to zero
  always_ff @(posedge clock) begin
    if (state_reg == arb_idle && pending) begin
      if (grant == owner_data) begin
        req_instr <= data_instr;
        req_addr <= data_addr;
        req_wdata <= data_wdata;
        req_wstrb <= data_wstrb;
      end else begin
        req_instr <= fetch_instr;
        req_addr <= fetch_addr;
        req_wdata <= '0;
        req_wstrb <= '0;
      end
    end
  end

  assign fetch_ready = (state_reg == arb_busy) && (owner_reg == owner_fetch) && req_ready;
  assign data_ready = (state_reg == arb_busy) && (owner_reg == owner_data) && req_ready;
  assign fetch_rdata = req_rdata;
  assign data_rdata = req_rdata;

  one_port_ready: assert property (@(posedge clock) disable iff (reset == 1'b0)
    !(fetch_ready && data_ready));

  // a new strobe must never meet the completion of the transaction before it
  no_strobe_in_busy: assert property (@(posedge clock) disable iff (reset == 1'b0)
    req_valid |-> !req_ready);

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;

  // one enable per data byte, all zero marks a read
  typedef logic [7:0] strb_t;

  typedef enum logic [0:0] {
    arb_idle,
    arb_busy
  } arb_state_t;

  typedef logic [0:0] owner_t;

  localparam owner_t owner_fetch = 1'b0;
  localparam owner_t owner_data = 1'b1;

endpackage

`default_nettype wire

/* hw/mem_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem (
  input  logic             clock,
  input  logic             reset,
  // instruction fetch port
  input  logic             fetch_valid,
  input  logic             fetch_instr,
  input  mem_pkg::addr_t   fetch_addr,
  output mem_pkg::data_t   fetch_rdata,
  output logic             fetch_ready,
  // data port
  input  logic             data_valid,
  input  logic             data_instr,
  input  mem_pkg::addr_t   data_addr,
  input  mem_pkg::data_t   data_wdata,
  input  mem_pkg::strb_t   data_wstrb,
  output mem_pkg::data_t   data_rdata,
  output logic             data_ready,
  // AXI4 master
  output mem_pkg::addr_t   m_axi_awaddr,
  output axi_pkg::len_t    m_axi_awlen,
  output axi_pkg::size_t   m_axi_awsize,
  output axi_pkg::burst_t  m_axi_awburst,
  output logic             m_axi_awlock,
  output axi_pkg::cache_t  m_axi_awcache,
  output axi_pkg::prot_t   m_axi_awprot,
  output axi_pkg::qos_t    m_axi_awqos,
  output logic             m_axi_awvalid,
  input  logic             m_axi_awready,
  output mem_pkg::data_t   m_axi_wdata,
  output mem_pkg::strb_t   m_axi_wstrb,
  output logic             m_axi_wlast,
  output logic             m_axi_wvalid,
  input  logic             m_axi_wready,
  input  axi_pkg::resp_t   m_axi_bresp,
  input  logic             m_axi_bvalid,
  output logic             m_axi_bready,
  output mem_pkg::addr_t   m_axi_araddr,
  output axi_pkg::len_t    m_axi_arlen,
  output axi_pkg::size_t   m_axi_arsize,
  output axi_pkg::burst_t  m_axi_arburst,
  output logic             m_axi_arlock,
  output axi_pkg::cache_t  m_axi_arcache,
  output axi_pkg::prot_t   m_axi_arprot,
  output axi_pkg::qos_t    m_axi_arqos,
  output logic             m_axi_arvalid,
  input  logic             m_axi_arready,
  input  mem_pkg::data_t   m_axi_rdata,
  input  axi_pkg::resp_t   m_axi_rresp,
  input  logic             m_axi_rlast,
  input  logic             m_axi_rvalid,
  output logic             m_axi_rready
);
  import mem_pkg::*;

  // single request path between the arbiter and the bridge
  logic  req_valid;
  logic  req_instr;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_wstrb;
  data_t req_rdata;
  logic  req_ready;

  mem_arbiter arbiter (
    .clock, .reset,
    .fetch_valid, .fetch_instr, .fetch_addr, .fetch_rdata, .fetch_ready,
    .data_valid, .data_instr, .data_addr, .data_wdata, .data_wstrb,
    .data_rdata, .data_ready,
    .req_valid, .req_instr, .req_addr, .req_wdata, .req_wstrb,
    .req_ready, .req_rdata
  );

  axi_master bridge (
    .clock, .reset,
    .req_valid, .req_instr, .req_addr, .req_wdata, .req_wstrb,
    .req_rdata, .req_ready,
    .m_axi_awaddr, .m_axi_awlen, .m_axi_awsize, .m_axi_awburst, .m_axi_awlock,
    .m_axi_awcache, .m_axi_awprot, .m_axi_awqos, .m_axi_awvalid, .m_axi_awready,
    .m_axi_wdata, .m_axi_wstrb, .m_axi_wlast, .m_axi_wvalid, .m_axi_wready,
    .m_axi_bresp, .m_axi_bvalid, .m_axi_bready,
    .m_axi_araddr, .m_axi_arlen, .m_axi_arsize, .m_axi_arburst, .m_axi_arlock,
    .m_axi_arcache, .m_axi_arprot, .m_axi_arqos, .m_axi_arvalid, .m_axi_arready,
    .m_axi_rdata, .m_axi_rresp, .m_axi_rlast, .m_axi_rvalid, .m_axi_rready
  );

endmodule

`default_nettype wire

/* src.f */
hw/mem_pkg.sv
hw/axi_pkg.sv
hw/mem_arbiter.sv
hw/axi_master.sv
hw/mem_subsystem.sv
dv/axi_mem_model.sv
dv/tb_mem_subsystem.sv
